//--- tests/lsu_golden.mem
// Columns (hex): test_id opcode insn src_a src_b tag expected_load_data
// Expected data is ignored for stores, all ops in program order
1 23 00002823 00000100 DEADBEEF 01 00000000
1 03 01002003 00000100 00000000 02 DEADBEEF
1 23 FE002C23 00000200 12345678 03 00000000
1 03 00802003 000001F0 00000000 04 12345678
1 03 FF802003 00000200 00000000 05 12345678
1 03 FF002003 00000120 00000000 06 DEADBEEF
// Word 0x300 built from byte and halfword lanes, ends as 8001A57F
2 23 00002023 00000300 00000000 07 00000000
2 23 000000A3 00000300 111111A5 08 00000000
2 23 00001123 00000300 FFFF8001 09 00000000
2 23 00000023 00000300 0000007F 0A 00000000
2 03 00002003 00000300 00000000 0B 8001A57F
2 03 00100003 00000300 00000000 0C FFFFFFA5
2 03 00104003 00000300 00000000 0D 000000A5
2 03 00000003 00000300 00000000 0E 0000007F
2 03 00201003 00000300 00000000 0F FFFF8001
2 03 00205003 00000300 00000000 10 00008001
2 03 00001003 00000300 00000000 11 FFFFA57F
2 03 00005003 00000300 00000000 12 0000A57F
2 03 00300003 00000300 00000000 13 FFFFFF80
2 03 00301003 00000300 00000000 14 FFFF8001
// Store burst then loads, 0x040 is written twice
3 23 00002023 00000040 AAAA0001 15 00000000
3 23 00002023 00000044 AAAA0002 16 00000000
3 23 00002023 00000048 AAAA0003 17 00000000
3 23 00002023 00000040 BBBB0004 18 00000000
3 03 00002003 00000040 00000000 19 BBBB0004
3 03 00002003 00000044 00000000 1A AAAA0002
3 03 00002003 00000048 00000000 1B AAAA0003
4 03 00002003 00000110 00000000 1C DEADBEEF
4 03 00002003 000001F8 00000000 1D 12345678
4 03 00002003 00000300 00000000 1E 8001A57F
4 03 00304003 00000300 00000000 1F 00000080
4 03 00002003 00000044 00000000 20 AAAA0002
4 03 00001003 00000048 00000000 21 00000003
// Reserved funct3 codes act as word ops
5 23 00004023 00000080 CAFEF00D 22 00000000
5 23 00004023 00000084 0BADC0DE 23 00000000
5 03 00003003 00000080 00000000 24 CAFEF00D
5 03 00006003 00000084 00000000 25 0BADC0DE
5 03 00207003 00000080 00000000 26 CAFEF00D
6 03 00002003 00000040 00000000 27 BBBB0004
6 03 00002003 00000044 00000000 28 AAAA0002
6 03 00002003 00000048 00000000 29 AAAA0003
6 03 00002003 00000080 00000000 2A CAFEF00D
6 03 00002003 00000084 00000000 2B 0BADC0DE
6 03 00002003 00000110 00000000 2C DEADBEEF
6 03 00002003 000001F8 00000000 2D 12345678

//--- lsu_top.f
hw/procyon_types_pkg.sv
hw/procyon_lsu_pkg.sv
hw/lsu_id.sv
hw/lsu_lq.sv
hw/lsu_sq.sv
hw/lsu_dmem.sv
hw/lsu_top.sv
tests/tb_clkgen.sv
tests/lsu_props.sv
tests/tb_lsu.sv

//--- Bender.yml
package:
  name: lsu_top

sources:
  - files:
      - hw/procyon_types_pkg.sv
      - hw/procyon_lsu_pkg.sv
      - hw/lsu_id.sv
      - hw/lsu_lq.sv
      - hw/lsu_sq.sv
      - hw/lsu_dmem.sv
      - hw/lsu_top.sv
  - target: test
    files:
      - tests/tb_clkgen.sv
      - tests/lsu_props.sv
      - tests/tb_lsu.sv

//--- tests/tb_lsu.sv
// Testbench top that reads the golden op list, issues ops into the LSU
// and checks load responses in order against the expected tag and data

`timescale 1ns/1ps

module tb_lsu
    import procyon_types_pkg::*;
    import procyon_lsu_pkg::*;
();

    localparam int N_OPS          = 45;
    localparam int FIELDS         = 7;
    localparam int TIMEOUT_CYCLES = 40 * N_OPS + 200;
    localparam int FILL_TEST      = 6;
    localparam int STALL_RELEASE  = 8;

    typedef struct packed {
        logic [7:0]    test_id;
        procyon_tag_t  tag;
        procyon_data_t data;
    } expect_t;

    logic        clk;
    logic        arst_n      = 1'b0;
    lsu_issue_t  issue       = '0;
    logic        issue_valid = 1'b0;
    logic        issue_ready;
    lsu_resp_t   resp;
    logic        resp_valid;
    logic        resp_ready  = 1'b0;

    logic [31:0] golden [N_OPS*FIELDS];
    int          gap [N_OPS];
    logic        bp_low [TIMEOUT_CYCLES];
    expect_t     exp_q [$];
    int          cycle_count = 0;
    int          checks      = 0;
    int          errors      = 0;
    logic        hold_resp   = 1'b0;
    logic        saw_stall   = 1'b0;

    tb_clkgen #(.PERIOD_NS(10.0)) u_clkgen (.o_clk(clk));

    lsu_top #(
        .LQ_DEPTH  (4),
        .SQ_DEPTH  (4),
        .MEM_WORDS (256)
    ) u_dut (
        .i_clk         (clk),
        .i_arst_n      (arst_n),
        .i_issue       (issue),
        .i_issue_valid (issue_valid),
        .o_issue_ready (issue_ready),
        .o_resp        (resp),
        .o_resp_valid  (resp_valid),
        .i_resp_ready  (resp_ready)
    );

    function automatic string test_name(input int id);
        case (id)
            1:       return "word_store_load";
            2:       return "byte_half_lanes";
            3:       return "store_load_order";
            4:       return "resp_backpressure";
            5:       return "funct3_default";
            6:       return "lq_fill_stall";
            default: return "unknown";
        endcase
    endfunction

    // Burst tests issue back to back
    function automatic bit has_idle_gaps(input int id);
        return (id == 1) || (id == 2) || (id == 5);
    endfunction

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    always @(posedge clk) begin
        resp_ready <= !hold_resp && !bp_low[cycle_count % TIMEOUT_CYCLES];
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles, %0d load responses never arrived",
                 cycle_count, exp_q.size());
        $display("Regression failed");
        $finish;
    end

    always @(posedge clk) begin : resp_check
        expect_t want;
        if (arst_n && resp_valid && resp_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("Unexpected response with tag %02h while no load was outstanding",
                         resp.tag);
                errors++;
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                checks++;
                assert (resp.tag == want.tag) else begin
                    $display("[FAIL] %s tag: expected %02h actual %02h",
                             test_name(want.test_id), want.tag, resp.tag);
                    errors++;
                end
                assert (resp.data == want.data) else begin
                    $display("[FAIL] %s data for tag %02h: expected %08h actual %08h",
                             test_name(want.test_id), want.tag, want.data, resp.data);
                    errors++;
                end
            end
        end
    end

    // Holds one op on the issue port until it is accepted
    task automatic issue_op(input int k);
        lsu_issue_t op;
        expect_t    want;
        int         b;
        int         stall;
        b         = k * FIELDS;
        op.opcode = procyon_opcode_t'(golden[b+1][6:0]);
        op.insn   = procyon_insn_u'(golden[b+2]);
        op.src_a  = golden[b+3];
        op.src_b  = golden[b+4];
        op.tag    = golden[b+5][TAG_WIDTH-1:0];
        issue       <= op;
        issue_valid <= 1'b1;
        stall = 0;
        @(posedge clk);
        while (!issue_ready) begin
            stall++;
            // Let responses flow again once the fill has stalled issue
            if (hold_resp && stall == STALL_RELEASE) begin
                hold_resp <= 1'b0;
                saw_stall = 1'b1;
            end
            @(posedge clk);
        end
        if (op.opcode == OPCODE_LOAD) begin
            want.test_id = golden[b][7:0];
            want.tag     = op.tag;
            want.data    = golden[b+6];
            exp_q.push_back(want);
        end
    endtask

    initial begin
        int i;
        int k;
        int cur;
        int t_checks;
        int t_errors;
        int n_tests;
        void'($urandom(43));
        $readmemh("tests/lsu_golden.mem", golden);
        for (i = 0; i < N_OPS; i++) begin
            gap[i] = has_idle_gaps(golden[i*FIELDS]) ? $urandom_range(0, 2) : 0;
        end
        for (i = 0; i < TIMEOUT_CYCLES; i++) begin
            bp_low[i] = ($urandom_range(0, 2) == 0);
        end
        assert (!$isunknown(golden[N_OPS*FIELDS-1])) else begin
            $display("Golden file is missing or holds fewer than %0d ops", N_OPS);
            errors++;
        end

        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        k       = 0;
        n_tests = 0;
        while (k < N_OPS) begin
            cur      = golden[k*FIELDS];
            t_checks = checks;
            t_errors = errors;
            if (cur == FILL_TEST) begin
                hold_resp <= 1'b1;
                saw_stall = 1'b0;
            end
            while (k < N_OPS && golden[k*FIELDS] == cur) begin
                issue_op(k);
                if (gap[k] > 0) begin
                    issue_valid <= 1'b0;
                    repeat (gap[k]) @(posedge clk);
                end
                k++;
            end
            issue_valid <= 1'b0;
            while (exp_q.size() != 0) begin
                @(posedge clk);
            end
            @(posedge clk);
            if (cur == FILL_TEST) begin
                assert (saw_stall) else begin
                    $display("Test %s: issue never stalled while responses were held back",
                             test_name(cur));
                    errors++;
                end
                hold_resp <= 1'b0;
            end
            n_tests++;
            $display("Test %s: %0d loads checked, %0d errors",
                     test_name(cur), checks - t_checks, errors - t_errors);
        end

        $display("Summary: %0d tests, %0d loads checked, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- tests/lsu_props.sv
// Concurrent checks on the LSU response port and queue allocation,
// bound into lsu_top

`timescale 1ns/1ps

module lsu_props
    import procyon_lsu_pkg::*;
(
    input logic      i_clk,
    input logic      i_arst_n,
    input lsu_resp_t i_resp,
    input logic      i_resp_valid,
    input logic      i_resp_ready,
    input logic      i_sq_en,
    input logic      i_lq_en
);

    // A pending response holds until the consumer takes it
    a_resp_hold: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        (i_resp_valid && !i_resp_ready) |=> (i_resp_valid && $stable(i_resp))
    ) else $error("Load response changed or dropped before it was accepted");

    a_resp_idle_after_reset: assert property (
        @(posedge i_clk) $rose(i_arst_n) |-> !i_resp_valid
    ) else $error("Response valid was high in the first cycle after reset");

    // An op goes to exactly one queue
    a_alloc_exclusive: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        !(i_sq_en && i_lq_en)
    ) else $error("Store and load queue were both allocated in one cycle");

endmodule

bind lsu_top lsu_props u_lsu_props (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_resp       (o_resp),
    .i_resp_valid (o_resp_valid),
    .i_resp_ready (i_resp_ready),
    .i_sq_en      (sq_en),
    .i_lq_en      (lq_en)
);

//--- tests/tb_clkgen.sv
// Free-running clock for the testbench

`timescale 1ns/1ps

module tb_clkgen #(
    parameter real PERIOD_NS = 10.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always #(PERIOD_NS / 2.0) o_clk = ~o_clk;

endmodule

//--- hw/lsu_top.sv
// Load/store unit top: decode, load and store queues, data memory

`timescale 1ns/1ps

module lsu_top
    import procyon_types_pkg::*;
    import procyon_lsu_pkg::*;
#(
    parameter int LQ_DEPTH  = 4,
    parameter int SQ_DEPTH  = 4,
    parameter int MEM_WORDS = 256
) (
    input  logic       i_clk,
    input  logic       i_arst_n,

    // Issue from the reservation station
    input  lsu_issue_t i_issue,
    input  logic       i_issue_valid,
    output logic       o_issue_ready,

    // Load results
    output lsu_resp_t  o_resp,
    output logic       o_resp_valid,
    input  logic       i_resp_ready
);

    localparam int SQ_CNT_W = $clog2(SQ_DEPTH+1);

    lsu_alloc_t          alloc;
    logic                lq_en;
    logic                sq_en;
    logic                lq_ready;
    logic                sq_ready;
    logic [SQ_CNT_W-1:0] sq_count;
    logic                st_done;
    lsu_mem_req_t        st_req;
    logic                st_valid;
    logic                st_ready;
    lsu_mem_req_t        ld_req;
    procyon_tag_t        ld_tag;
    logic                ld_valid;
    logic                ld_ready;

    lsu_id u_lsu_id (
        .i_issue       (i_issue),
        .i_issue_valid (i_issue_valid),
        .o_issue_ready (o_issue_ready),
        .i_lq_ready    (lq_ready),
        .i_sq_ready    (sq_ready),
        .o_alloc       (alloc),
        .o_lq_en       (lq_en),
        .o_sq_en       (sq_en)
    );

    lsu_lq #(
        .LQ_DEPTH (LQ_DEPTH),
        .SQ_DEPTH (SQ_DEPTH)
    ) u_lsu_lq (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_alloc    (alloc),
        .i_alloc_en (lq_en),
        .o_ready    (lq_ready),
        .i_sq_count (sq_count),
        .i_st_done  (st_done),
        .o_ld_req   (ld_req),
        .o_ld_tag   (ld_tag),
        .o_ld_valid (ld_valid),
        .i_ld_ready (ld_ready)
    );

    lsu_sq #(
        .SQ_DEPTH (SQ_DEPTH)
    ) u_lsu_sq (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_alloc    (alloc),
        .i_alloc_en (sq_en),
        .o_ready    (sq_ready),
        .o_sq_count (sq_count),
        .o_st_req   (st_req),
        .o_st_valid (st_valid),
        .i_st_ready (st_ready),
        .o_st_done  (st_done)
    );

    lsu_dmem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_lsu_dmem (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_st_req     (st_req),
        .i_st_valid   (st_valid),
        .o_st_ready   (st_ready),
        .i_ld_req     (ld_req),
        .i_ld_valid   (ld_valid),
        .o_ld_ready   (ld_ready),
        .i_ld_tag     (ld_tag),
        .o_resp       (o_resp),
        .o_resp_valid (o_resp_valid),
        .i_resp_ready (i_resp_ready)
    );

endmodule

//--- hw/lsu_dmem.sv
// Single-port data memory with store-first arbitration, byte-lane writes,
// load lane extraction and the load response register

`timescale 1ns/1ps

module lsu_dmem
    import procyon_types_pkg::*;
    import procyon_lsu_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic         i_clk,
    input  logic         i_arst_n,

    // Store side
    input  lsu_mem_req_t i_st_req,
    input  logic         i_st_valid,
    output logic         o_st_ready,

    // Load side
    input  lsu_mem_req_t i_ld_req,
    input  logic         i_ld_valid,
    output logic         o_ld_ready,
    input  procyon_tag_t i_ld_tag,

    // Load response
    output lsu_resp_t    o_resp,
    output logic         o_resp_valid,
    input  logic         i_resp_ready
);

    localparam int IDX_W     = $clog2(MEM_WORDS);
    localparam int NUM_BYTES = DATA_WIDTH / 8;

    procyon_data_t        mem [MEM_WORDS];
    logic [IDX_W-1:0]     st_idx;
    logic [IDX_W-1:0]     ld_idx;
    logic [NUM_BYTES-1:0] st_mask;
    procyon_data_t        st_wdata;
    procyon_data_t        rd_word;
    procyon_data_t        ld_data;
    logic [7:0]           rd_byte;
    logic [15:0]          rd_half;
    logic                 st_hs;
    logic                 ld_hs;
    lsu_resp_t            resp_q;
    logic                 resp_valid;

    // Stores always win the port
    assign o_st_ready = 1'b1;
    assign st_hs      = i_st_valid & o_st_ready;
    assign o_ld_ready = ~i_st_valid & (~resp_valid | i_resp_ready);
    assign ld_hs      = i_ld_valid & o_ld_ready;

    // Word index wraps modulo MEM_WORDS
    assign st_idx = i_st_req.addr[IDX_W+1:2];
    assign ld_idx = i_ld_req.addr[IDX_W+1:2];

    always_comb begin
        case (i_st_req.lsu_func)
            LSU_FUNC_SB: begin
                st_mask  = NUM_BYTES'(1) << i_st_req.addr[1:0];
                st_wdata = {NUM_BYTES{i_st_req.data[7:0]}};
            end
            LSU_FUNC_SH: begin
                st_mask  = i_st_req.addr[1] ? 4'b1100 : 4'b0011;
                st_wdata = {2{i_st_req.data[15:0]}};
            end
            default: begin
                st_mask  = '1;
                st_wdata = i_st_req.data;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (st_hs) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (st_mask[b]) begin
                    mem[st_idx][8*b +: 8] <= st_wdata[8*b +: 8];
                end
            end
        end
    end

    // Lane select, then extend per function
    assign rd_word = mem[ld_idx];
    assign rd_byte = rd_word[{i_ld_req.addr[1:0], 3'b000} +: 8];
    assign rd_half = i_ld_req.addr[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        case (i_ld_req.lsu_func)
            LSU_FUNC_LB:  ld_data = {{(DATA_WIDTH-8){rd_byte[7]}}, rd_byte};
            LSU_FUNC_LBU: ld_data = {{(DATA_WIDTH-8){1'b0}}, rd_byte};
            LSU_FUNC_LH:  ld_data = {{(DATA_WIDTH-16){rd_half[15]}}, rd_half};
            LSU_FUNC_LHU: ld_data = {{(DATA_WIDTH-16){1'b0}}, rd_half};
            default:      ld_data = rd_word;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (ld_hs) begin
            resp_q.tag  <= i_ld_tag;
            resp_q.data <= ld_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            resp_valid <= 1'b0;
        end else if (ld_hs) begin
            resp_valid <= 1'b1;
        end else if (i_resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    assign o_resp       = resp_q;
    assign o_resp_valid = resp_valid;

endmodule

//--- hw/lsu_sq.sv
// In-order store queue draining its head store into data memory

`timescale 1ns/1ps

module lsu_sq
    import procyon_lsu_pkg::*;
#(
    parameter int SQ_DEPTH = 4
) (
    input  logic                          i_clk,
    input  logic                          i_arst_n,

    // Allocation from decode
    input  lsu_alloc_t                    i_alloc,
    input  logic                          i_alloc_en,
    output logic                          o_ready,

    // Occupancy, sampled by the load queue at allocation
    output logic [$clog2(SQ_DEPTH+1)-1:0] o_sq_count,

    // Store request to memory
    output lsu_mem_req_t                  o_st_req,
    output logic                          o_st_valid,
    input  logic                          i_st_ready,
    output logic                          o_st_done
);

    localparam int PTR_W = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(SQ_DEPTH+1);

    lsu_mem_req_t     sq_entry [SQ_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    assign o_ready    = (count != CNT_W'(SQ_DEPTH));
    assign o_sq_count = count;
    assign o_st_valid = (count != '0);
    assign o_st_req   = sq_entry[head];
    assign o_st_done  = o_st_valid & i_st_ready;

    // The tag is dropped here, stores never answer
    always_ff @(posedge i_clk) begin
        if (i_alloc_en) begin
            sq_entry[tail].lsu_func <= i_alloc.lsu_func;
            sq_entry[tail].addr     <= i_alloc.addr;
            sq_entry[tail].data     <= i_alloc.data;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (i_alloc_en) begin
                tail <= (tail == PTR_W'(SQ_DEPTH-1)) ? '0 : tail + 1'b1;
            end
            if (o_st_done) begin
                head <= (head == PTR_W'(SQ_DEPTH-1)) ? '0 : head + 1'b1;
            end
            case ({i_alloc_en, o_st_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hw/lsu_lq.sv
// In-order load queue, each entry tracks how many older stores are
// still waiting to drain before it may read memory

`timescale 1ns/1ps

module lsu_lq
    import procyon_types_pkg::*;
    import procyon_lsu_pkg::*;
#(
    parameter int LQ_DEPTH = 4,
    parameter int SQ_DEPTH = 4
) (
    input  logic                          i_clk,
    input  logic                          i_arst_n,

    // Allocation from decode
    input  lsu_alloc_t                    i_alloc,
    input  logic                          i_alloc_en,
    output logic                          o_ready,

    // Store queue progress
    input  logic [$clog2(SQ_DEPTH+1)-1:0] i_sq_count,
    input  logic                          i_st_done,

    // Load request to memory
    output lsu_mem_req_t                  o_ld_req,
    output procyon_tag_t                  o_ld_tag,
    output logic                          o_ld_valid,
    input  logic                          i_ld_ready
);

    localparam int PTR_W    = (LQ_DEPTH > 1) ? $clog2(LQ_DEPTH) : 1;
    localparam int CNT_W    = $clog2(LQ_DEPTH+1);
    localparam int SQ_CNT_W = $clog2(SQ_DEPTH+1);

    procyon_lsu_func_t   lq_func [LQ_DEPTH];
    procyon_addr_t       lq_addr [LQ_DEPTH];
    procyon_tag_t        lq_tag  [LQ_DEPTH];
    logic [SQ_CNT_W-1:0] lq_wait [LQ_DEPTH];
    logic [PTR_W-1:0]    head;
    logic [PTR_W-1:0]    tail;
    logic [CNT_W-1:0]    count;
    logic                ld_hs;

    assign o_ready    = (count != CNT_W'(LQ_DEPTH));
    assign o_ld_valid = (count != '0) && (lq_wait[head] == '0);
    assign ld_hs      = o_ld_valid & i_ld_ready;

    always_comb begin
        o_ld_req.lsu_func = lq_func[head];
        o_ld_req.addr     = lq_addr[head];
        o_ld_req.data     = '0;
    end

    assign o_ld_tag = lq_tag[head];

    always_ff @(posedge i_clk) begin
        if (i_alloc_en) begin
            lq_func[tail] <= i_alloc.lsu_func;
            lq_addr[tail] <= i_alloc.addr;
            lq_tag[tail]  <= i_alloc.tag;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < LQ_DEPTH; i++) begin
                lq_wait[i] <= '0;
            end
        end else begin
            // A store draining this cycle is already older than the new load
            for (int i = 0; i < LQ_DEPTH; i++) begin
                if (i_alloc_en && (tail == PTR_W'(i))) begin
                    lq_wait[i] <= i_sq_count - SQ_CNT_W'(i_st_done);
                end else if (i_st_done && (lq_wait[i] != '0)) begin
                    lq_wait[i] <= lq_wait[i] - 1'b1;
                end
            end
            if (i_alloc_en) begin
                tail <= (tail == PTR_W'(LQ_DEPTH-1)) ? '0 : tail + 1'b1;
            end
            if (ld_hs) begin
                head <= (head == PTR_W'(LQ_DEPTH-1)) ? '0 : head + 1'b1;
            end
            case ({i_alloc_en, ld_hs})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hw/lsu_id.sv
// LSU decode: function decode, immediate generation, address calculation
// and steering of issued ops into the load or store queue

`timescale 1ns/1ps

module lsu_id
    import procyon_types_pkg::*;
    import procyon_lsu_pkg::*;
(
    // Issue port from the reservation station
    input  lsu_issue_t  i_issue,
    input  logic        i_issue_valid,
    output logic        o_issue_ready,

    // Queue space
    input  logic        i_lq_ready,
    input  logic        i_sq_ready,

    // Allocation into the queues
    output lsu_alloc_t  o_alloc,
    output logic        o_lq_en,
    output logic        o_sq_en
);

    procyon_lsu_func_t lsu_func;
    procyon_data_t     imm_i;
    procyon_data_t     imm_s;
    logic              is_store;

    // Anything that is not a store goes down the load path
    assign is_store = (i_issue.opcode == OPCODE_STORE);

    // Both immediates sign-extend from insn[31]
    assign imm_i = {{(DATA_WIDTH-12){i_issue.insn.i.imm[11]}}, i_issue.insn.i.imm};
    assign imm_s = {{(DATA_WIDTH-12){i_issue.insn.s.imm_hi[6]}},
                    i_issue.insn.s.imm_hi, i_issue.insn.s.imm_lo};

    // Function from funct3, reserved codes act as word ops
    always_comb begin
        case (i_issue.insn.i.funct3)
            3'b000:  lsu_func = is_store ? LSU_FUNC_SB : LSU_FUNC_LB;
            3'b001:  lsu_func = is_store ? LSU_FUNC_SH : LSU_FUNC_LH;
            3'b010:  lsu_func = is_store ? LSU_FUNC_SW : LSU_FUNC_LW;
            3'b100:  lsu_func = is_store ? LSU_FUNC_SW : LSU_FUNC_LBU;
            3'b101:  lsu_func = is_store ? LSU_FUNC_SW : LSU_FUNC_LHU;
            default: lsu_func = is_store ? LSU_FUNC_SW : LSU_FUNC_LW;
        endcase
    end

    always_comb begin
        o_alloc.lsu_func = lsu_func;
        o_alloc.addr     = i_issue.src_a + (is_store ? imm_s : imm_i);
        o_alloc.data     = i_issue.src_b;
        o_alloc.tag      = i_issue.tag;
    end

    // Ready follows the queue this op is headed for
    assign o_issue_ready = is_store ? i_sq_ready : i_lq_ready;

    assign o_sq_en = i_issue_valid & is_store & i_sq_ready;
    assign o_lq_en = i_issue_valid & ~is_store & i_lq_ready;

endmodule

//--- hw/procyon_lsu_pkg.sv
// LSU function encoding, instruction word views and the LSU transfer structs

package procyon_lsu_pkg;

    import procyon_types_pkg::*;

    typedef enum logic [3:0] {
        LSU_FUNC_LB  = 4'b0000,
        LSU_FUNC_LH  = 4'b0001,
        LSU_FUNC_LW  = 4'b0010,
        LSU_FUNC_LBU = 4'b0100,
        LSU_FUNC_LHU = 4'b0101,
        LSU_FUNC_SB  = 4'b1000,
        LSU_FUNC_SH  = 4'b1001,
        LSU_FUNC_SW  = 4'b1010
    } procyon_lsu_func_t;

    // I-format view, used by loads
    typedef struct packed {
        logic [11:0]     imm;
        logic [4:0]      rs1;
        logic [2:0]      funct3;
        logic [4:0]      rd;
        procyon_opcode_t opcode;
    } procyon_insn_i_t;

    // S-format view, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0]      imm_hi;
        logic [4:0]      rs2;
        logic [4:0]      rs1;
        logic [2:0]      funct3;
        logic [4:0]      imm_lo;
        procyon_opcode_t opcode;
    } procyon_insn_s_t;

    typedef union packed {
        procyon_insn_i_t i;
        procyon_insn_s_t s;
    } procyon_insn_u;

    // Op as it leaves the reservation station
    typedef struct packed {
        procyon_opcode_t opcode;
        procyon_insn_u   insn;
        procyon_data_t   src_a;
        procyon_data_t   src_b;
        procyon_tag_t    tag;
    } lsu_issue_t;

    typedef struct packed {
        procyon_lsu_func_t lsu_func;
        procyon_addr_t     addr;
        procyon_data_t     data;
        procyon_tag_t      tag;
    } lsu_alloc_t;

    typedef struct packed {
        procyon_tag_t  tag;
        procyon_data_t data;
    } lsu_resp_t;

    typedef struct packed {
        procyon_lsu_func_t lsu_func;
        procyon_addr_t     addr;
        procyon_data_t     data;
    } lsu_mem_req_t;

endpackage

//--- hw/procyon_types_pkg.sv
// Core-wide widths and the data, address, tag and opcode types

package procyon_types_pkg;

    parameter int DATA_WIDTH = 32;
    parameter int ADDR_WIDTH = 32;
    parameter int TAG_WIDTH  = 6;

    typedef logic [DATA_WIDTH-1:0] procyon_data_t;
    typedef logic [ADDR_WIDTH-1:0] procyon_addr_t;
    typedef logic [TAG_WIDTH-1:0]  procyon_tag_t;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_OPIMM  = 7'b0010011,
        OPCODE_OP     = 7'b0110011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011
    } procyon_opcode_t;

endpackage
